// File: common/gpu_settings.svh
`ifndef GPU_SETTINGS_SVH
`define GPU_SETTINGS_SVH

// hardware warps and the width of a warp id
`define GPU_NUM_WARPS 8
`define GPU_WARP_ID_W 3

// task store capacity and its pointer width
`define GPU_TASK_DEPTH 256
`define GPU_TASK_PTR_W 8

// shared register pool
`define GPU_NUM_REGS 32

`endif

// File: common/task_pkg.sv
package task_pkg;

	// raw host word with the valid bit on top
	typedef struct packed {
		logic       valid;
		logic [7:0] sw_warp_id;
		logic [8:0] start_pc;
		logic [7:0] active_mask;
		logic [2:0] nreg;
	} host_word_t;

	// descriptor as held in the task store
	typedef struct packed {
		logic       valid;
		logic [7:0] sw_warp_id;
		logic [8:0] start_pc;
		logic [7:0] active_mask;
		logic [2:0] nreg;
	} task_t;

	// registers are handed out in even-sized blocks
	function automatic logic [3:0] reg_cost(input task_t t);
		reg_cost = t.nreg[0] ? {1'b0, t.nreg} + 4'd1 : {1'b0, t.nreg} + 4'd2;
	endfunction

endpackage

// File: common/warp_pkg.sv
`include "gpu_settings.svh"

package warp_pkg;

	// hardware warp slot
	typedef logic [`GPU_WARP_ID_W-1:0] warp_id_t;

	// record sent to fetch, simt stack and register allocation
	typedef struct packed {
		warp_id_t   hw_warp;
		logic [7:0] sw_warp_id;
		logic [8:0] start_pc;
		logic [7:0] active_mask;
		logic [2:0] nreg;
	} launch_t;

endpackage

// File: run_sim.sh
#!/usr/bin/env bash
# compile and run the dispatch testbench with verilator

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -Wno-fatal -f vlog.f \
	--top-module tb_gpu_dispatch -Mdir obj_dir -o tb_gpu_dispatch
if [ $? -ne 0 ]; then
	echo "verilator compile failed"
	exit 1
fi

./obj_dir/tb_gpu_dispatch > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
	echo "simulation exited with status $run_status"
	exit 1
fi

if grep -q "Testbench failed" "$log"; then
	exit 1
fi
if ! grep -q "Testbench passed" "$log"; then
	echo "simulation ended without a result"
	exit 1
fi
exit 0

// File: sim/tb_gpu_dispatch.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module tb_gpu_dispatch;

	// nominal cycles per test in run order
	localparam int test_cycles = 40 + 90 + 110 + 70 + 70;
	localparam int cycle_limit = test_cycles * 4;
	localparam int cnt_w = `GPU_TASK_PTR_W + 1;

	typedef logic [cnt_w-1:0] count_t;

	logic clk;
	logic rst;
	logic wr_en;
	task_pkg::host_word_t wr_word;
	logic start;
	logic clear;
	logic exit_valid;
	warp_pkg::warp_id_t exit_warp;
	logic launch_valid;
	warp_pkg::launch_t launch;
	logic finished;
	count_t loaded_count;

	integer seed;
	int cycles = 0;
	int checks = 0;
	int errors = 0;
	int launches_seen = 0;
	int launches_exp = 0;

	// reference model of the dispatch rules
	task_pkg::host_word_t pending_q[$];
	warp_pkg::launch_t exp_q[$];
	warp_pkg::warp_id_t free_q[$];
	int free_regs;
	int warp_cost [`GPU_NUM_WARPS];
	logic [`GPU_NUM_WARPS-1:0] busy;

	gpu_dispatch_top dut (
		.clk          (clk),
		.rst          (rst),
		.wr_en        (wr_en),
		.wr_word      (wr_word),
		.start        (start),
		.clear        (clear),
		.exit_valid   (exit_valid),
		.exit_warp    (exit_warp),
		.launch_valid (launch_valid),
		.launch       (launch),
		.finished     (finished),
		.loaded_count (loaded_count)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycle_limit) begin
			$display("timeout: tests did not complete within %0d cycles", cycle_limit);
			$display("Testbench failed");
			$finish;
		end
	end

	always @(negedge clk) begin
		if (launch_valid === 1'b1) begin
			launches_seen = launches_seen + 1;
		end
	end

	// odd register counts round up by one, even ones by two
	function automatic int cost_of(input logic [2:0] nreg);
		return nreg[0] ? int'(nreg) + 1 : int'(nreg) + 2;
	endfunction

	task automatic check_launch(input string name, input warp_pkg::launch_t got,
		input warp_pkg::launch_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic check_flag(input string name, input bit got, input bit want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic check_count(input string name, input count_t got, input count_t want);
		checks++;
		if (got !== want) begin
			errors++;
			$display("ERR %s: got %h expected %h", name, got, want);
		end
	endtask

	task automatic model_reset();
		pending_q.delete();
		exp_q.delete();
		free_q.delete();
		for (int i = 0; i < `GPU_NUM_WARPS; i++) begin
			free_q.push_back(warp_pkg::warp_id_t'(i));
		end
		free_regs = `GPU_NUM_REGS;
		busy = '0;
	endtask

	// store order while a warp and enough registers are free
	task automatic model_dispatch();
		warp_pkg::launch_t e;
		while (pending_q.size() > 0 && free_q.size() > 0 &&
			free_regs >= cost_of(pending_q[0].nreg)) begin
			e.hw_warp = free_q.pop_front();
			e.sw_warp_id = pending_q[0].sw_warp_id;
			e.start_pc = pending_q[0].start_pc;
			e.active_mask = pending_q[0].active_mask;
			e.nreg = pending_q[0].nreg;
			free_regs -= cost_of(e.nreg);
			warp_cost[e.hw_warp] = cost_of(e.nreg);
			busy[e.hw_warp] = 1'b1;
			exp_q.push_back(e);
			launches_exp++;
			void'(pending_q.pop_front());
		end
	endtask

	task automatic pulse_clear();
		@(posedge clk);
		#2;
		clear = 1'b1;
		@(posedge clk);
		#2;
		clear = 1'b0;
		model_reset();
	endtask

	task automatic load_random(input logic valid, input logic [2:0] nreg);
		task_pkg::host_word_t w;
		w.valid = valid;
		w.sw_warp_id = 8'($random(seed));
		w.start_pc = 9'($random(seed));
		w.active_mask = 8'($random(seed));
		w.nreg = nreg;
		@(posedge clk);
		#2;
		wr_en = 1'b1;
		wr_word = w;
		@(posedge clk);
		#2;
		wr_en = 1'b0;
		if (valid) begin
			pending_q.push_back(w);
		end
	endtask

	task automatic start_run();
		@(posedge clk);
		#2;
		start = 1'b1;
		@(posedge clk);
		#2;
		start = 1'b0;
		model_dispatch();
	endtask

	// exit returns the warp to the back of the free list
	task automatic retire_warp(input warp_pkg::warp_id_t w);
		@(posedge clk);
		#2;
		exit_valid = 1'b1;
		exit_warp = w;
		@(posedge clk);
		#2;
		exit_valid = 1'b0;
		free_q.push_back(w);
		free_regs += warp_cost[w];
		busy[w] = 1'b0;
		model_dispatch();
	endtask

	task automatic collect_launches();
		warp_pkg::launch_t want;
		while (exp_q.size() > 0) begin
			want = exp_q.pop_front();
			do @(negedge clk); while (launch_valid !== 1'b1);
			check_launch("launch", launch, want);
		end
	endtask

	task automatic check_quiet();
		repeat (8) begin
			@(negedge clk);
			check_flag("launch_valid", launch_valid, 1'b0);
		end
	endtask

	task automatic retire_all();
		for (int i = 0; i < `GPU_NUM_WARPS; i++) begin
			if (busy[i]) begin
				retire_warp(warp_pkg::warp_id_t'(i));
			end
		end
		collect_launches();
	endtask

	// finished must rise within a few cycles of the last exit
	task automatic wait_finished();
		int n;
		n = 0;
		while (finished !== 1'b1 && n < 8) begin
			@(negedge clk);
			n++;
		end
		check_flag("finished", finished, 1'b1);
	endtask

	task automatic finish_test(input string name, input int errs_before);
		check_count("launch_count", count_t'(launches_seen), count_t'(launches_exp));
		if (errors == errs_before) begin
			$display("test %s: ok", name);
		end else begin
			$display("test %s: %0d errors", name, errors - errs_before);
		end
	endtask

	task automatic test_single_task();
		int errs;
		errs = errors;
		pulse_clear();
		load_random(1'b1, 3'($random(seed)));
		start_run();
		collect_launches();
		check_flag("finished", finished, 1'b0);
		retire_all();
		wait_finished();
		finish_test("single_task", errs);
	endtask

	task automatic test_warp_reuse();
		int errs;
		errs = errors;
		pulse_clear();
		// costs of two keep registers out of the way
		for (int i = 0; i < 9; i++) begin
			load_random(1'b1, 3'($random(seed)) & 3'd1);
		end
		start_run();
		collect_launches();
		check_quiet();
		retire_warp(3'd5);
		collect_launches();
		retire_all();
		wait_finished();
		finish_test("warp_reuse", errs);
	endtask

	task automatic test_reg_limit();
		int errs;
		logic [2:0] nregs [7];
		errs = errors;
		// first five use all 32 registers
		nregs = '{3'd1, 3'd7, 3'd7, 3'd7, 3'd5, 3'd7, 3'd0};
		pulse_clear();
		foreach (nregs[i]) begin
			load_random(1'b1, nregs[i]);
		end
		start_run();
		collect_launches();
		check_quiet();
		// two registers back are not enough
		retire_warp(3'd0);
		collect_launches();
		check_quiet();
		retire_warp(3'd4);
		collect_launches();
		check_quiet();
		retire_warp(3'd1);
		collect_launches();
		retire_all();
		wait_finished();
		finish_test("reg_limit", errs);
	endtask

	task automatic test_invalid_words();
		int errs;
		int seen_before;
		int n_valid;
		logic v;
		errs = errors;
		seen_before = launches_seen;
		n_valid = 0;
		pulse_clear();
		for (int i = 0; i < 7; i++) begin
			v = (i % 3 != 1);
			if (v) begin
				n_valid++;
			end
			load_random(v, 3'($random(seed)) & 3'd1);
		end
		check_count("loaded_count", loaded_count, count_t'(n_valid));
		start_run();
		collect_launches();
		check_quiet();
		retire_all();
		wait_finished();
		check_count("launches", count_t'(launches_seen - seen_before), count_t'(n_valid));
		finish_test("invalid_words", errs);
	endtask

	task automatic test_clear_restart();
		int errs;
		errs = errors;
		check_flag("finished", finished, 1'b1);
		pulse_clear();
		check_flag("finished", finished, 1'b0);
		check_count("loaded_count", loaded_count, '0);
		// empty store finishes without a launch
		start_run();
		wait_finished();
		check_quiet();
		pulse_clear();
		load_random(1'b1, 3'($random(seed)));
		load_random(1'b1, 3'($random(seed)));
		start_run();
		collect_launches();
		retire_all();
		wait_finished();
		finish_test("clear_restart", errs);
	endtask

	initial begin
		rst = 1'b0;
		wr_en = 1'b0;
		wr_word = '0;
		start = 1'b0;
		clear = 1'b0;
		exit_valid = 1'b0;
		exit_warp = '0;
		seed = 95;
		model_reset();
		repeat (5) @(posedge clk);
		#2;
		rst = 1'b1;
		test_single_task();
		test_warp_reuse();
		test_reg_limit();
		test_invalid_words();
		test_clear_restart();
		$display("tests 5, checks %0d, errors %0d", checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// File: src/gpu_dispatch_top.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module gpu_dispatch_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     wr_en,
	input  task_pkg::host_word_t     wr_word,
	input  logic                     start,
	input  logic                     clear,
	input  logic                     exit_valid,
	input  warp_pkg::warp_id_t       exit_warp,
	output logic                     launch_valid,
	output warp_pkg::launch_t        launch,
	output logic                     finished,
	output logic [`GPU_TASK_PTR_W:0] loaded_count
);

	logic loading;
	logic task_wr;
	task_pkg::task_t task_desc;
	logic dispatch;
	warp_pkg::launch_t mgr_launch;
	logic exit_pop_valid;
	warp_pkg::warp_id_t exit_pop_warp;
	logic exit_ack;

	task_loader u_loader (
		.clk          (clk),
		.rst          (rst),
		.clear        (clear),
		.wr_en        (wr_en),
		.wr_word      (wr_word),
		.loading      (loading),
		.task_wr      (task_wr),
		.task_desc    (task_desc),
		.loaded_count (loaded_count)
	);

	task_manager u_manager (
		.clk            (clk),
		.rst            (rst),
		.start          (start),
		.clear          (clear),
		.task_wr        (task_wr),
		.task_desc      (task_desc),
		.exit_pop_valid (exit_pop_valid),
		.exit_pop_warp  (exit_pop_warp),
		.exit_ack       (exit_ack),
		.loading        (loading),
		.dispatch       (dispatch),
		.launch         (mgr_launch),
		.finished       (finished)
	);

	warp_launch u_launch (
		.clk            (clk),
		.rst            (rst),
		.clear          (clear),
		.dispatch       (dispatch),
		.launch_in      (mgr_launch),
		.exit_valid     (exit_valid),
		.exit_warp      (exit_warp),
		.exit_ack       (exit_ack),
		.exit_pop_valid (exit_pop_valid),
		.exit_pop_warp  (exit_pop_warp),
		.launch_valid   (launch_valid),
		.launch         (launch)
	);

endmodule

// File: src/task_loader.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module task_loader (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     clear,
	input  logic                     wr_en,
	input  task_pkg::host_word_t     wr_word,
	input  logic                     loading,
	output logic                     task_wr,
	output task_pkg::task_t          task_desc,
	output logic [`GPU_TASK_PTR_W:0] loaded_count
);

	logic accept;

	// words without the valid bit are dropped here
	assign accept = wr_en && wr_word.valid && loading;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			task_wr <= 1'b0;
			loaded_count <= '0;
		end else begin
			task_wr <= accept;
			if (clear) begin
				loaded_count <= '0;
			end else if (accept) begin
				loaded_count <= loaded_count + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (accept) begin
			task_desc.valid <= wr_word.valid;
			task_desc.sw_warp_id <= wr_word.sw_warp_id;
			task_desc.start_pc <= wr_word.start_pc;
			task_desc.active_mask <= wr_word.active_mask;
			task_desc.nreg <= wr_word.nreg;
		end
	end

	// accepted tasks never outnumber the store slots
	a_count_bounded: assert property (
		@(posedge clk) disable iff (!rst)
		loaded_count <= `GPU_TASK_DEPTH
	);

endmodule

// File: src/warp_launch.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module warp_launch (
	input  logic               clk,
	input  logic               rst,
	input  logic               clear,
	input  logic               dispatch,
	input  warp_pkg::launch_t  launch_in,
	input  logic               exit_valid,
	input  warp_pkg::warp_id_t exit_warp,
	input  logic               exit_ack,
	output logic               exit_pop_valid,
	output warp_pkg::warp_id_t exit_pop_warp,
	output logic               launch_valid,
	output warp_pkg::launch_t  launch
);

	logic [`GPU_NUM_WARPS-1:0] active;
	warp_pkg::launch_t ctx [`GPU_NUM_WARPS];
	// slot of the most recent launch
	warp_pkg::warp_id_t bcast_warp;
	logic exit_empty;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			active <= '0;
			launch_valid <= 1'b0;
		end else if (clear) begin
			active <= '0;
			launch_valid <= 1'b0;
		end else begin
			launch_valid <= dispatch;
			if (dispatch) begin
				active[launch_in.hw_warp] <= 1'b1;
			end
			if (exit_valid) begin
				active[exit_warp] <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (dispatch) begin
			ctx[launch_in.hw_warp] <= launch_in;
			bcast_warp <= launch_in.hw_warp;
		end
	end

	// broadcast reads back from the context table
	assign launch = ctx[bcast_warp];

	sync_fifo #(
		.item_t  (warp_pkg::warp_id_t),
		.depth   (`GPU_NUM_WARPS),
		.preload (1'b0)
	) u_exit_queue (
		.clk       (clk),
		.rst       (rst),
		.clear     (clear),
		.push      (exit_valid),
		.push_item (exit_warp),
		.pop       (exit_ack),
		.pop_item  (exit_pop_warp),
		.empty     (exit_empty),
		.full      ()
	);

	assign exit_pop_valid = !exit_empty;

	// exits only for warps that were launched and have not exited yet
	a_exit_active: assert property (
		@(posedge clk) disable iff (!rst)
		exit_valid |-> active[exit_warp]
	);

endmodule

// File: task_manager/sync_fifo.sv
`timescale 1ns/10ps

module sync_fifo #(
	parameter type item_t = logic [7:0],
	parameter int depth = 8,
	parameter bit preload = 1'b0
) (
	input  logic  clk,
	input  logic  rst,
	input  logic  clear,
	input  logic  push,
	input  item_t push_item,
	input  logic  pop,
	output item_t pop_item,
	output logic  empty,
	output logic  full
);

	localparam int ptr_w = $clog2(depth);
	// preloaded list starts out full
	localparam logic [ptr_w:0] wptr_init = preload ? {1'b1, {ptr_w{1'b0}}} : '0;

	item_t mem [depth];
	logic [ptr_w:0] wptr;
	logic [ptr_w:0] rptr;

	// extra top bit tells full from empty
	assign empty = (wptr == rptr);
	assign full = (wptr[ptr_w] != rptr[ptr_w]) && (wptr[ptr_w-1:0] == rptr[ptr_w-1:0]);
	assign pop_item = mem[rptr[ptr_w-1:0]];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wptr <= wptr_init;
			rptr <= '0;
		end else if (clear) begin
			wptr <= wptr_init;
			rptr <= '0;
		end else begin
			if (push) begin
				wptr <= wptr + 1'b1;
			end
			if (pop) begin
				rptr <= rptr + 1'b1;
			end
		end
	end

	generate
		if (preload) begin : g_preload
			// identity sequence 0..depth-1
			always_ff @(posedge clk or negedge rst) begin
				if (!rst || clear) begin
					for (int i = 0; i < depth; i++) begin
						mem[i] <= item_t'(i);
					end
				end else if (push) begin
					mem[wptr[ptr_w-1:0]] <= push_item;
				end
			end
		end else begin : g_plain
			always_ff @(posedge clk) begin
				if (push && !clear) begin
					mem[wptr[ptr_w-1:0]] <= push_item;
				end
			end
		end
	endgenerate

	a_no_overflow: assert property (@(posedge clk) disable iff (!rst) push |-> !full);

endmodule

// File: task_manager/task_manager.sv
`timescale 1ns/10ps
`include "gpu_settings.svh"

module task_manager (
	input  logic               clk,
	input  logic               rst,
	input  logic               start,
	input  logic               clear,
	input  logic               task_wr,
	input  task_pkg::task_t    task_desc,
	input  logic               exit_pop_valid,
	input  warp_pkg::warp_id_t exit_pop_warp,
	output logic               exit_ack,
	output logic               loading,
	output logic               dispatch,
	output warp_pkg::launch_t  launch,
	output logic               finished
);

	localparam int reg_w = $clog2(`GPU_NUM_REGS + 1);
	localparam int act_w = $clog2(`GPU_NUM_WARPS + 1);

	typedef enum logic [1:0] {
		st_waiting  = 2'b00,
		st_working  = 2'b01,
		st_complete = 2'b10,
		st_clear    = 2'b11
	} state_t;

	state_t state;
	task_pkg::task_t store [`GPU_TASK_DEPTH];
	logic [`GPU_TASK_PTR_W:0] wptr;
	logic [`GPU_TASK_PTR_W:0] rptr;
	logic [`GPU_TASK_PTR_W:0] fill;
	// store slot of the task running on each warp
	logic [`GPU_TASK_PTR_W-1:0] warp_task [`GPU_NUM_WARPS];
	logic [reg_w-1:0] free_regs;
	logic [reg_w-1:0] head_cost;
	logic [reg_w-1:0] exit_cost;
	logic [act_w-1:0] active_count;
	task_pkg::task_t head;
	task_pkg::task_t exit_task;
	warp_pkg::warp_id_t free_warp;
	logic warp_empty;
	logic pending;
	logic store_full;
	logic can_dispatch;
	logic all_done;

	assign head = store[rptr[`GPU_TASK_PTR_W-1:0]];
	assign exit_task = store[warp_task[exit_pop_warp]];
	assign head_cost = reg_w'(task_pkg::reg_cost(head));
	assign exit_cost = reg_w'(task_pkg::reg_cost(exit_task));

	assign fill = wptr - rptr;
	assign pending = (fill != '0);
	// count the write already in flight from the loader
	assign store_full = (fill == `GPU_TASK_DEPTH) ||
		(task_wr && fill == `GPU_TASK_DEPTH - 1);

	assign loading = (state == st_waiting) && !store_full && !start && !clear;
	assign can_dispatch = (state == st_working) && pending && !warp_empty &&
		(free_regs >= head_cost);
	assign exit_ack = (state == st_working) && exit_pop_valid;
	assign all_done = !pending && (active_count == '0);

	sync_fifo #(
		.item_t  (warp_pkg::warp_id_t),
		.depth   (`GPU_NUM_WARPS),
		.preload (1'b1)
	) u_free_warps (
		.clk       (clk),
		.rst       (rst),
		.clear     (state == st_clear),
		.push      (exit_ack),
		.push_item (exit_pop_warp),
		.pop       (can_dispatch),
		.pop_item  (free_warp),
		.empty     (warp_empty),
		.full      ()
	);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			state <= st_waiting;
			dispatch <= 1'b0;
			finished <= 1'b0;
		end else begin
			dispatch <= can_dispatch;
			case (state)
				st_waiting: begin
					if (clear) begin
						state <= st_clear;
					end else if (start) begin
						state <= st_working;
					end
				end
				st_working: begin
					if (clear) begin
						state <= st_clear;
					end else if (all_done) begin
						state <= st_complete;
						finished <= 1'b1;
					end
				end
				st_complete: begin
					if (clear) begin
						state <= st_clear;
						finished <= 1'b0;
					end
				end
				st_clear: begin
					state <= st_waiting;
					finished <= 1'b0;
				end
			endcase
		end
	end

	// pointers and pools are refilled in the clear state
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			wptr <= '0;
			rptr <= '0;
			free_regs <= reg_w'(`GPU_NUM_REGS);
			active_count <= '0;
		end else if (state == st_clear) begin
			wptr <= '0;
			rptr <= '0;
			free_regs <= reg_w'(`GPU_NUM_REGS);
			active_count <= '0;
		end else begin
			if (task_wr) begin
				wptr <= wptr + 1'b1;
			end
			if (can_dispatch) begin
				rptr <= rptr + 1'b1;
			end
			free_regs <= free_regs - (can_dispatch ? head_cost : '0) +
				(exit_ack ? exit_cost : '0);
			active_count <= active_count + act_w'(can_dispatch) - act_w'(exit_ack);
		end
	end

	always_ff @(posedge clk) begin
		if (task_wr) begin
			store[wptr[`GPU_TASK_PTR_W-1:0]] <= task_desc;
		end
		if (can_dispatch) begin
			warp_task[free_warp] <= rptr[`GPU_TASK_PTR_W-1:0];
			launch.hw_warp <= free_warp;
			launch.sw_warp_id <= head.sw_warp_id;
			launch.start_pc <= head.start_pc;
			launch.active_mask <= head.active_mask;
			launch.nreg <= head.nreg;
		end
	end

	a_regs_bounded: assert property (
		@(posedge clk) disable iff (!rst)
		free_regs <= reg_w'(`GPU_NUM_REGS)
	);

	a_warps_bounded: assert property (
		@(posedge clk) disable iff (!rst)
		active_count <= act_w'(`GPU_NUM_WARPS)
	);

endmodule

// File: vlog.f
+incdir+common
common/task_pkg.sv
common/warp_pkg.sv
task_manager/sync_fifo.sv
src/task_loader.sv
task_manager/task_manager.sv
src/warp_launch.sv
src/gpu_dispatch_top.sv
sim/tb_gpu_dispatch.sv
